// File: calc_direct_tests.txt
# first line: ambient light_color light_pos.x light_pos.y light_pos.z (hex, Q8.8)
# then: name ray_id is_shadow miss k n.x n.y n.z p.x p.y p.z expected (hex or none)
0180 0100 0000 0200 0000
lit_full           01 1 1 0100 0000 0100 0000 0000 0100 0000 0280
lit_half           02 1 1 0200 0000 0080 0000 0000 0100 0000 0400
lit_negative       03 1 1 0100 0000 ff00 0000 0000 0100 0000 0180
lit_saturate       04 1 1 ffff 0000 0400 0000 0000 0100 0000 ffff
lit_clamp_high     05 1 1 0100 0000 0400 0000 0000 0100 0000 0280
lit_mixed          06 1 1 0080 0040 0080 0040 ff80 0100 ff00 0130
lit_fraction       07 1 1 0133 0000 0055 0000 0000 0100 0000 0232
lit_quarter        08 1 1 0100 0000 0180 0000 0000 01c0 0000 01e0
lit_zero_k         09 1 1 0000 0000 0100 0000 0000 0100 0000 0000
lit_negative_sat   0a 1 1 ffff 0000 ff00 0000 0000 0100 0000 ffff
lit_perpendicular  0b 1 1 0200 0100 0000 0000 0000 0100 0000 0300
lit_full_half_k    0c 1 1 0080 0000 0100 0000 0000 0100 0000 0140
occ_unit           11 1 0 0100 0000 0100 0000 0000 0100 0000 0180
miss_a             18 0 1 0100 0000 0000 0000 0000 0000 0000 0040
hit_a              1c 0 0 0100 0000 0100 0000 0000 0100 0000 none
lit_half_unit      0d 1 1 0100 0000 0080 0000 0000 0100 0000 0200
occ_odd            12 1 0 0333 0000 0000 0000 0000 0000 0000 04cc
miss_b             19 0 1 ffff 0000 0000 0000 0000 0000 0000 0040
lit_far            0e 1 1 0100 0000 0080 0000 0000 0000 0000 0280
occ_saturate       13 1 0 ffff 0000 0000 0000 0000 0000 0000 ffff
hit_b              1d 0 0 0200 0000 0000 0000 0000 0000 0000 none
lit_behind         0f 1 1 0100 0000 0100 0000 0000 0300 0000 0180
occ_small          14 1 0 0010 0000 0000 0000 0000 0000 0000 0018
miss_c             1a 0 1 0000 0000 0000 0000 0000 0000 0000 0040
lit_big_k          10 1 1 2000 0000 0180 0000 0000 01c0 0000 3c00
occ_half           15 1 0 8000 0000 0000 0000 0000 0000 0000 c000
occ_zero           16 1 0 0000 0000 0000 0000 0000 0000 0000 0000
hit_c              1e 0 0 ffff 0000 0000 0000 0000 0000 0000 none
occ_two            17 1 0 0200 0000 0000 0000 0000 0000 0000 0300
miss_d             1b 0 1 0080 0000 0100 0000 0000 0100 0000 0040
burst_lit_a        1f 1 1 0100 0000 0100 0000 0000 0100 0000 0280
burst_occ_a        20 1 0 0100 0000 0000 0000 0000 0000 0000 0180
burst_miss_a       21 0 1 0100 0000 0000 0000 0000 0000 0000 0040
burst_lit_b        22 1 1 0200 0000 0080 0000 0000 0100 0000 0400
burst_hit_a        23 0 0 0100 0000 0000 0000 0000 0000 0000 none
burst_lit_c        24 1 1 ffff 0000 0400 0000 0000 0100 0000 ffff
occ_k_ab           25 1 0 00ab 0000 0000 0000 0000 0000 0000 0100

// File: flist.f
rt_pkg.sv
direct_shade_pipe.sv
credit_fifo.sv
small_arbiter.sv
calc_direct.sv
tb_calc_direct.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
rm -f sim.log
verilator --binary -j 0 -f flist.f --top-module tb_calc_direct -o sim_calc_direct \
	&& ./obj_dir/sim_calc_direct 2>&1 | tee sim.log \
	|| { echo "Simulation did not complete"; exit 1; }
grep -q "ERRORS FOUND" sim.log \
	&& { echo "Simulation reported a failure"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// File: tb_calc_direct.sv
`timescale 1ns/1ns
`default_nettype none

module tb_calc_direct;

	logic            clk;
	logic            arst_n;
	logic            in_valid;
	rt_pkg::ray_id_t in_ray_id;
	logic            in_is_shadow;
	logic            in_miss;
	rt_pkg::color_t  in_k;
	rt_pkg::vector_t in_n;
	rt_pkg::vector_t in_p_int;
	logic            in_stall;
	rt_pkg::color_t  ambient;
	rt_pkg::color_t  light_color;
	rt_pkg::vector_t light_pos;
	logic            out_valid;
	rt_pkg::ray_id_t out_ray_id;
	rt_pkg::color_t  out_color;
	logic            out_stall;

	// Packets in file order
	string           t_name[$];
	rt_pkg::ray_id_t t_id[$];
	logic            t_shadow[$];
	logic            t_miss[$];
	rt_pkg::color_t  t_k[$];
	rt_pkg::vector_t t_n[$];
	rt_pkg::vector_t t_p[$];

	// Expected results by ray_id
	string           exp_name[256];
	rt_pkg::color_t  exp_color[256];
	logic            pending[256];
	int              expected_results;
	int              results_seen;
	logic            tests_loaded;
	logic [31:0]     gap_rng;
	logic [31:0]     stall_rng;

	calc_direct DUT (
		.clk, .arst_n,
		.in_valid, .in_ray_id, .in_is_shadow, .in_miss, .in_k, .in_n, .in_p_int, .in_stall,
		.ambient, .light_color, .light_pos,
		.out_valid, .out_ray_id, .out_color, .out_stall
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_color(input string name, input rt_pkg::color_t expected,
	                             input rt_pkg::color_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic load_tests();
		int              fd;
		int              code;
		string           line;
		string           name;
		string           exp_s;
		rt_pkg::ray_id_t id;
		logic            sh, ms, scene_done;
		logic [15:0]     k, nx, ny, nz, px, py, pz, ev;
		foreach (pending[i]) begin
			pending[i] = 1'b0;
		end
		fd = $fopen("calc_direct_tests.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open calc_direct_tests.txt");
		end
		scene_done = 1'b0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 3 || line.substr(0, 0) == "#") begin
				continue;
			end
			if (!scene_done) begin
				code = $sscanf(line, "%h %h %h %h %h", ambient, light_color, px, py, pz);
				if (code != 5) begin
					abort_run("scene line in calc_direct_tests.txt is malformed");
				end
				light_pos  = {px, py, pz};
				scene_done = 1'b1;
			end else begin
				code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %s", name, id, sh, ms,
				               k, nx, ny, nz, px, py, pz, exp_s);
				if (code != 12 || exp_name[id] != "") begin
					abort_run({"malformed or duplicate test line: ", line});
				end
				t_name.push_back(name);
				t_id.push_back(id);
				t_shadow.push_back(sh);
				t_miss.push_back(ms);
				t_k.push_back(k);
				t_n.push_back({nx, ny, nz});
				t_p.push_back({px, py, pz});
				exp_name[id] = name;
				// Primary hits give no result
				if (exp_s != "none") begin
					code = $sscanf(exp_s, "%h", ev);
					exp_color[id] = ev;
					pending[id]   = 1'b1;
					expected_results++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic insert_gap();
		gap_rng = xorshift(gap_rng);
		if (gap_rng[1:0] == 2'b00) begin
			@(negedge clk);
			in_valid = 1'b0;
			repeat (int'(gap_rng[4:2])) @(negedge clk);
		end
	endtask

	// Hold the packet until the DUT takes it
	task automatic send_packet(input int t);
		logic accepted;
		accepted = 1'b0;
		@(negedge clk);
		in_valid     = 1'b1;
		in_ray_id    = t_id[t];
		in_is_shadow = t_shadow[t];
		in_miss      = t_miss[t];
		in_k         = t_k[t];
		in_n         = t_n[t];
		in_p_int     = t_p[t];
		while (!accepted) begin
			#1;
			accepted = !in_stall;
			@(posedge clk);
			if (!accepted) begin
				@(negedge clk);
			end
		end
	endtask

	task automatic check_result(input rt_pkg::ray_id_t id, input rt_pkg::color_t color);
		if (!pending[id]) begin
			abort_run($sformatf("result for ray_id %0h that is unknown or already finished", id));
		end else begin
			compare_color(exp_name[id], exp_color[id], color);
			pending[id] = 1'b0;
			results_seen++;
		end
	endtask

	initial begin : stimulus
		int quiet;
		in_valid         = 1'b0;
		in_ray_id        = '0;
		in_is_shadow     = 1'b0;
		in_miss          = 1'b0;
		in_k             = '0;
		in_n             = '0;
		in_p_int         = '0;
		ambient          = '0;
		light_color      = '0;
		light_pos        = '0;
		out_stall        = 1'b0;
		arst_n           = 1'b0;
		expected_results = 0;
		results_seen     = 0;
		tests_loaded     = 1'b0;
		gap_rng          = 32'h4ba3426c;
		stall_rng        = xorshift(32'h4ba3426c);
		load_tests();
		tests_loaded = 1'b1;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		foreach (t_name[t]) begin
			insert_gap();
			send_packet(t);
		end
		@(negedge clk);
		in_valid = 1'b0;
		// Drained once out_valid stays low longer than the deepest path
		quiet = 0;
		while (quiet < rt_pkg::SHADE_LATENCY + 4) begin
			@(negedge clk);
			quiet = out_valid ? 0 : quiet + 1;
		end
		// Extra cycles to catch a repeated result
		repeat (40) @(negedge clk);
		compare_count("result_count", expected_results, results_seen);
		$display("NO ERRORS");
		$finish;
	end

	// Random back-pressure and result capture
	initial begin : result_monitor
		logic            transfer;
		rt_pkg::ray_id_t id;
		rt_pkg::color_t  color;
		forever begin
			@(negedge clk);
			stall_rng = xorshift(stall_rng);
			out_stall = stall_rng[2:0] < 3'd5;
			#1;
			transfer = arst_n && out_valid && !out_stall;
			id       = out_ray_id;
			color    = out_color;
			@(posedge clk);
			if (transfer) begin
				check_result(id, color);
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (tests_loaded);
		limit = t_name.size() * 40 + 200;
		repeat (limit) @(posedge clk);
		abort_run($sformatf("timeout after %0d cycles with %0d of %0d results received",
		                    limit, results_seen, expected_results));
	end

endmodule : tb_calc_direct

`default_nettype wire

// File: calc_direct.sv
`timescale 1ns/1ns
`default_nettype none

// Direct-lighting stage, sorts rays into lit, occluded, miss and dropped
module calc_direct (
	input  logic            clk,
	input  logic            arst_n,

	// From point intersection
	input  logic            in_valid,
	input  rt_pkg::ray_id_t in_ray_id,
	input  logic            in_is_shadow,
	input  logic            in_miss,
	input  rt_pkg::color_t  in_k,
	input  rt_pkg::vector_t in_n,
	input  rt_pkg::vector_t in_p_int,
	output logic            in_stall,

	// Scene levels
	input  rt_pkg::color_t  ambient,
	input  rt_pkg::color_t  light_color,
	input  rt_pkg::vector_t light_pos,

	// To buffer manager
	output logic            out_valid,
	output rt_pkg::ray_id_t out_ray_id,
	output rt_pkg::color_t  out_color,
	input  logic            out_stall
);

	logic lit_req, occ_req, miss_req;
	logic lit_acc, occ_acc;

	logic            lit_can_reserve, occ_can_reserve;
	logic            pipe_valid;
	rt_pkg::ray_id_t pipe_ray_id;
	rt_pkg::color_t  pipe_color;

	logic            lit_valid, occ_valid;
	rt_pkg::ray_id_t lit_ray_id, occ_ray_id;
	rt_pkg::color_t  lit_color, occ_color_q;

	logic [31:0]     occ_prod;
	rt_pkg::color_t  occ_color;
	logic [2:0]      arb_stall;

	// Ray class. A primary hit matches none of these and is dropped
	assign lit_req  = in_valid && in_is_shadow && in_miss;
	assign occ_req  = in_valid && in_is_shadow && !in_miss;
	assign miss_req = in_valid && !in_is_shadow && in_miss;

	assign lit_acc = lit_req && lit_can_reserve;
	assign occ_acc = occ_req && occ_can_reserve;

	assign in_stall = (lit_req && !lit_can_reserve) ||
	                  (occ_req && !occ_can_reserve) ||
	                  (miss_req && arb_stall[rt_pkg::SRC_MISS]);

	// Occluded shading is ambient only
	assign occ_prod  = ambient * in_k;
	assign occ_color = (|occ_prod[31:24]) ? rt_pkg::COLOR_MAX : occ_prod[23:8];

	direct_shade_pipe u_shade (
		.clk, .arst_n,
		.in_valid(lit_acc), .in_ray_id,
		.k(in_k), .ambient, .light_color,
		.n(in_n), .p_int(in_p_int), .light_pos,
		.out_valid(pipe_valid), .out_ray_id(pipe_ray_id), .out_color(pipe_color)
	);

	credit_fifo #(.DEPTH(rt_pkg::SHADE_FIFO_DEPTH)) u_lit_fifo (
		.clk, .arst_n,
		.reserve(lit_acc), .push(pipe_valid),
		.push_ray_id(pipe_ray_id), .push_color(pipe_color),
		.can_reserve(lit_can_reserve),
		.out_valid(lit_valid), .out_ray_id(lit_ray_id), .out_color(lit_color),
		.out_stall(arb_stall[rt_pkg::SRC_LIT])
	);

	// Reserve and push land together, nothing is in flight here
	credit_fifo #(.DEPTH(rt_pkg::OCC_FIFO_DEPTH)) u_occ_fifo (
		.clk, .arst_n,
		.reserve(occ_acc), .push(occ_acc),
		.push_ray_id(in_ray_id), .push_color(occ_color),
		.can_reserve(occ_can_reserve),
		.out_valid(occ_valid), .out_ray_id(occ_ray_id), .out_color(occ_color_q),
		.out_stall(arb_stall[rt_pkg::SRC_OCC])
	);

	small_arbiter u_arb (
		.clk, .arst_n,
		.valid_in({miss_req, occ_valid, lit_valid}),
		.ray_id_lit(lit_ray_id), .ray_id_occ(occ_ray_id), .ray_id_miss(in_ray_id),
		.color_lit(lit_color), .color_occ(occ_color_q), .color_miss(rt_pkg::MISS_COLOR),
		.stall_in(arb_stall),
		.out_valid, .out_ray_id, .out_color, .out_stall
	);

endmodule : calc_direct

`default_nettype wire

// File: small_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module small_arbiter (
	input  logic            clk,
	input  logic            arst_n,
	input  logic [2:0]      valid_in,
	input  rt_pkg::ray_id_t ray_id_lit,
	input  rt_pkg::ray_id_t ray_id_occ,
	input  rt_pkg::ray_id_t ray_id_miss,
	input  rt_pkg::color_t  color_lit,
	input  rt_pkg::color_t  color_occ,
	input  rt_pkg::color_t  color_miss,
	output logic [2:0]      stall_in,
	output logic            out_valid,
	output rt_pkg::ray_id_t out_ray_id,
	output rt_pkg::color_t  out_color,
	input  logic            out_stall
);

	rt_pkg::arb_src_e ptr;
	rt_pkg::arb_src_e sel;
	rt_pkg::arb_src_e cand;
	logic             found;
	logic             load;
	logic [2:0]       take;

	// First valid source at or after the pointer
	always_comb begin
		sel   = ptr;
		cand  = ptr;
		found = 1'b0;
		for (int i = 0; i < 3; i++) begin
			cand = rt_pkg::arb_src_e'(2'((int'(ptr) + i) % 3));
			if (!found && valid_in[cand]) begin
				sel   = cand;
				found = 1'b1;
			end
		end
	end

	assign load     = found && (!out_valid || !out_stall);
	assign take     = load ? (3'b001 << sel) : 3'b000;
	assign stall_in = ~take;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr       <= rt_pkg::SRC_LIT;
			out_valid <= 1'b0;
		end else begin
			if (load) begin
				out_valid <= 1'b1;
				case (sel)
					rt_pkg::SRC_LIT: ptr <= rt_pkg::SRC_OCC;
					rt_pkg::SRC_OCC: ptr <= rt_pkg::SRC_MISS;
					default:         ptr <= rt_pkg::SRC_LIT;
				endcase
			end else if (!out_stall) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			case (sel)
				rt_pkg::SRC_LIT: begin
					out_ray_id <= ray_id_lit;
					out_color  <= color_lit;
				end
				rt_pkg::SRC_OCC: begin
					out_ray_id <= ray_id_occ;
					out_color  <= color_occ;
				end
				default: begin
					out_ray_id <= ray_id_miss;
					out_color  <= color_miss;
				end
			endcase
		end
	end

	// A source just served gives way to any other source that is waiting
	a_round_robin: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) && $past(load) && load && |(valid_in & ~$past(take))
		|-> take != $past(take));

	// Result held steady for the buffer manager
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_stall |=> out_valid && $stable(out_ray_id) && $stable(out_color));

endmodule : small_arbiter

`default_nettype wire

// File: credit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
	parameter int DEPTH = 8
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            reserve,
	input  logic            push,
	input  rt_pkg::ray_id_t push_ray_id,
	input  rt_pkg::color_t  push_color,
	output logic            can_reserve,
	output logic            out_valid,
	output rt_pkg::ray_id_t out_ray_id,
	output rt_pkg::color_t  out_color,
	input  logic            out_stall
);

	rt_pkg::ray_id_t mem_ray_id [DEPTH];
	rt_pkg::color_t  mem_color  [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(DEPTH):0]   count;
	// Slots promised to items still in the upstream pipe
	logic [$clog2(DEPTH):0]   resv;
	logic [$clog2(DEPTH)+1:0] occupancy;
	logic                     pop;

	assign pop         = out_valid && !out_stall;
	assign occupancy   = {1'b0, count} + {1'b0, resv};
	assign can_reserve = occupancy < DEPTH;
	assign out_valid   = count != '0;
	assign out_ray_id  = mem_ray_id[rd_ptr];
	assign out_color   = mem_color[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem_ray_id[wr_ptr] <= push_ray_id;
			mem_color[wr_ptr]  <= push_color;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			resv   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// A push retires one reservation
			case ({reserve, push})
				2'b10:   resv <= resv + 1'b1;
				2'b01:   resv <= resv - 1'b1;
				default: resv <= resv;
			endcase
		end
	end

	a_push_reserved: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> (resv != '0) || reserve);

	a_no_overbook: assert property (@(posedge clk) disable iff (!arst_n)
		occupancy <= DEPTH);

endmodule : credit_fifo

`default_nettype wire

// File: direct_shade_pipe.sv
`timescale 1ns/1ns
`default_nettype none

// K * (ambient + light_color * clamp(dot(N, light_pos - p_int)))
module direct_shade_pipe (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_valid,
	input  rt_pkg::ray_id_t in_ray_id,
	input  rt_pkg::color_t  k,
	input  rt_pkg::color_t  ambient,
	input  rt_pkg::color_t  light_color,
	input  rt_pkg::vector_t n,
	input  rt_pkg::vector_t p_int,
	input  rt_pkg::vector_t light_pos,
	output logic            out_valid,
	output rt_pkg::ray_id_t out_ray_id,
	output rt_pkg::color_t  out_color
);

	logic [rt_pkg::SHADE_LATENCY-1:0] vld_q;
	rt_pkg::ray_id_t                  id_q [rt_pkg::SHADE_LATENCY];

	// Stage 1 registers
	logic signed [16:0] d_x, d_y, d_z;
	rt_pkg::vector_t    n_q1;
	rt_pkg::color_t     k_q1;

	// Stage 2
	logic signed [34:0] dot_sum;
	logic [8:0]         dot_clamp;
	logic [8:0]         dot_q2;
	rt_pkg::color_t     k_q2;

	// Stage 3
	logic [24:0]        lit_prod;
	logic [17:0]        lit_sum;
	rt_pkg::color_t     lit_q3;
	rt_pkg::color_t     k_q3;

	// Stage 4
	logic [31:0]        fin_prod;

	// Valid shift register, the only control state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[rt_pkg::SHADE_LATENCY-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		id_q[0] <= in_ray_id;
		for (int i = 1; i < rt_pkg::SHADE_LATENCY; i++) begin
			id_q[i] <= id_q[i-1];
		end
	end

	// Q16.16 sum of products, back to Q8.8 by dropping 8 bits
	assign dot_sum = $signed(n_q1.x) * d_x + $signed(n_q1.y) * d_y + $signed(n_q1.z) * d_z;

	always_comb begin
		if (dot_sum[34]) begin
			dot_clamp = '0;
		end else if (dot_sum[34:8] >= 27'(rt_pkg::ONE_Q)) begin
			dot_clamp = 9'(rt_pkg::ONE_Q);
		end else begin
			dot_clamp = dot_sum[16:8];
		end
	end

	assign lit_prod = light_color * dot_q2;
	assign lit_sum = {1'b0, lit_prod[24:8]} + {2'b00, ambient};
	assign fin_prod = lit_q3 * k_q3;

	always_ff @(posedge clk) begin
		// Light vector
		d_x  <= $signed(light_pos.x) - $signed(p_int.x);
		d_y  <= $signed(light_pos.y) - $signed(p_int.y);
		d_z  <= $signed(light_pos.z) - $signed(p_int.z);
		n_q1 <= n;
		k_q1 <= k;

		dot_q2 <= dot_clamp;
		k_q2   <= k_q1;

		lit_q3 <= (lit_sum > 18'(rt_pkg::COLOR_MAX)) ? rt_pkg::COLOR_MAX : lit_sum[15:0];
		k_q3   <= k_q2;

		out_color <= (|fin_prod[31:24]) ? rt_pkg::COLOR_MAX : fin_prod[23:8];
	end

	assign out_valid  = vld_q[rt_pkg::SHADE_LATENCY-1];
	assign out_ray_id = id_q[rt_pkg::SHADE_LATENCY-1];

endmodule : direct_shade_pipe

`default_nettype wire

// File: rt_pkg.sv
`default_nettype none

package rt_pkg;

	// Field widths
	localparam int COLOR_W = 16;
	localparam int COORD_W = 16;
	localparam int RAY_ID_W = 8;

	// Unsigned Q8.8 color channel
	typedef logic [COLOR_W-1:0] color_t;

	// Signed Q8.8 coordinate
	typedef logic signed [COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

	typedef logic [RAY_ID_W-1:0] ray_id_t;

	// Saturation value of a color channel
	localparam color_t COLOR_MAX = '1;

	// 1.0 in Q8.8
	localparam int ONE_Q = 256;

	// Background color for primary rays that hit nothing (0.25)
	localparam color_t MISS_COLOR = 16'h0040;

	// Depth of the full-shading pipeline
	localparam int SHADE_LATENCY = 4;

	localparam int SHADE_FIFO_DEPTH = 8;
	localparam int OCC_FIFO_DEPTH = 4;

	// Arbiter sources, in the bit order of the arbiter valid and stall vectors
	typedef enum logic [1:0] {
		SRC_LIT  = 2'd0,
		SRC_OCC  = 2'd1,
		SRC_MISS = 2'd2
	} arb_src_e;

endpackage : rt_pkg

`default_nettype wire
